// File: sim.f
hw/dbg_types_pkg.sv
hw/dbg_map_pkg.sv
hw/sel_debounce.sv
hw/capture_fsm.sv
hw/probe_snapshot.sv
hw/led_probe_mux.sv
hw/wb_probe_port.sv
hw/debug_monitor_top.sv
verification/tb_debug_monitor.sv

// File: Makefile
TOP := tb_debug_monitor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build folder"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: verification/tb_debug_monitor.sv
`default_nettype none

module tb_debug_monitor
	import dbg_types_pkg::*, dbg_map_pkg::*;
();

	localparam int ACK_TIMEOUT = 8;
	localparam int POLL_LIMIT  = 4;

	logic       clk = 1'b0;
	logic       arst_n;
	word_t      sw;
	cpu_probe_t probe;
	word_t      led;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	probe_sel_t wb_adr;
	word_t      wb_dat_w;
	word_t      wb_dat_r;
	logic       wb_ack;

	integer     seed;

	// Expected LED state, compared while check_en is high
	logic       check_en  = 1'b0;
	string      test_name = "idle";
	probe_sel_t exp_sel;
	cpu_probe_t exp_probe;
	word_t      exp_sw;

	probe_sel_t codes[$];

	debug_monitor_top dut_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.sw       (sw),
		.probe    (probe),
		.led      (led),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #4 clk = ~clk;

	////////////////////
	// Reference model

	function automatic word_t ref_word(input probe_sel_t sel, input cpu_probe_t p,
		input word_t sw_val);
		word_t      w;
		logic [7:0] f;
		w = sw_val;
		if (sel == SEL_FLAGS) begin
			// Flags from the top, each one followed by a zero
			f = p.flags;
			w = '0;
			for (int i = 0; i < 8; i++) begin
				w = {w[13:0], f[7], 1'b0};
				f = {f[6:0], 1'b0};
			end
		end else if (sel >= SEL_REG_BASE && sel < SEL_REG_BASE + 8'd8) begin
			w = p.regs[reg_addr_t'(sel - SEL_REG_BASE)];
		end else begin
			case (sel)
				SEL_IF_PC:    w = p.if_pc;
				SEL_IF_INST:  w = p.if_inst;
				SEL_ID_INST:  w = p.id_inst;
				SEL_ID_PC:    w = p.id_pc;
				SEL_EXE_PC:   w = p.exe_pc;
				SEL_ALU_OP1:  w = p.alu_op1;
				SEL_ALU_OP2:  w = p.alu_op2;
				SEL_ALU_RES:  w = p.alu_res;
				SEL_WB_RES:   w = p.wb_res;
				SEL_MEM_DATA: w = p.mem_data;
				SEL_MEM_ADDR: w = p.mem_addr;
				default:      w = sw_val;
			endcase
		end
		return w;
	endfunction

	function automatic cpu_probe_t rand_probe();
		logic [319:0] v;
		v = '0;
		for (int i = 0; i < 10; i++) begin
			v = {v[287:0], 32'($random(seed))};
		end
		return v[311:0];
	endfunction

	// Random probe that cannot hit the breakpoint
	function automatic cpu_probe_t miss_probe(input word_t bp);
		cpu_probe_t p;
		p = rand_probe();
		if (p.exe_pc == bp) begin
			p.exe_pc = ~bp;
		end
		return p;
	endfunction

	////////////////////
	// Checks and waits

	task automatic check_val(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "Check %s did not match", name);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Test failures found");
		$fatal(1, "Timed out waiting for %s", what);
	endtask

	always @(negedge clk) begin
		if (check_en) begin
			check_val(test_name, ref_word(exp_sel, exp_probe, exp_sw), led);
		end
	end

	task automatic wb_xfer(input logic we, input probe_sel_t adr, input word_t dat,
		output word_t rdata);
		int waited;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		waited = 0;
		@(negedge clk);
		while (!wb_ack) begin
			if (waited == ACK_TIMEOUT) begin
				abort_on_timeout("wb_ack");
			end
			waited++;
			@(negedge clk);
		end
		check_val("ack latency", 16'd1, word_t'(waited));
		rdata = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		check_val("ack width", 16'd0, word_t'(wb_ack));
	endtask

	// Drive a select code and probe, then open the LED window once debounced
	task automatic hold_code(input probe_sel_t code, input cpu_probe_t p);
		word_t sw_val;
		sw_val   = {code, 8'($random(seed))};
		check_en = 1'b0;
		@(posedge clk);
		sw    <= sw_val;
		probe <= p;
		repeat (DEBOUNCE_CYCLES + 2) @(posedge clk);
		exp_sel   = code;
		exp_probe = p;
		exp_sw    = sw_val;
		test_name = $sformatf("led code %h", code);
		check_en  = 1'b1;
	endtask

	task automatic show_probe(input cpu_probe_t p);
		check_en = 1'b0;
		@(posedge clk);
		probe <= p;
		@(posedge clk);
		exp_probe = p;
		check_en  = 1'b1;
		@(negedge clk);
	endtask

	////////////////////
	// Stimulus

	initial begin
		word_t      rdata;
		word_t      bp;
		cpu_probe_t hit;
		int         tries;

		seed      = 86;
		arst_n    = 1'b0;
		sw        = '0;
		probe     = '0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		exp_sel   = '0;
		exp_probe = '0;
		exp_sw    = '0;

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_val("reset led", 16'h0000, led);
		check_val("reset ack", 16'h0000, word_t'(wb_ack));

		codes = '{SEL_FLAGS, SEL_IF_PC, SEL_IF_INST, SEL_ID_INST, SEL_ID_PC, SEL_EXE_PC,
			SEL_ALU_OP1, SEL_ALU_OP2, SEL_ALU_RES, SEL_WB_RES, SEL_MEM_DATA, SEL_MEM_ADDR};
		for (int i = 0; i < REG_COUNT; i++) begin
			codes.push_back(SEL_REG_BASE + probe_sel_t'(i));
		end
		// Two codes that fall back to sw
		codes.push_back(8'h55);
		codes.push_back(8'hA7);

		foreach (codes[i]) begin
			hold_code(codes[i], rand_probe());
			repeat (3) @(negedge clk);
		end

		// Short glitch on the select byte
		hold_code(SEL_ALU_RES, rand_probe());
		test_name = "select glitch";
		@(posedge clk);
		sw <= {SEL_ALU_OP1, exp_sw[7:0]};
		repeat (DEBOUNCE_CYCLES - 4) @(posedge clk);
		sw <= exp_sw;
		repeat (DEBOUNCE_CYCLES + 4) @(negedge clk);

		test_name = "led during bus reads";
		foreach (codes[i]) begin
			wb_xfer(1'b0, codes[i], '0, rdata);
			check_val($sformatf("bus read %h", codes[i]),
				ref_word(codes[i], exp_probe, exp_sw), rdata);
		end
		wb_xfer(1'b0, ADR_CTRL, '0, rdata);
		check_val("ctrl live", 16'h0000, rdata);

		////////////////////
		// Breakpoint capture

		bp = word_t'($random(seed));
		hold_code(SEL_EXE_PC, miss_probe(bp));
		wb_xfer(1'b1, ADR_BP_PC, bp, rdata);
		wb_xfer(1'b0, ADR_BP_PC, '0, rdata);
		check_val("breakpoint readback", bp, rdata);
		wb_xfer(1'b1, ADR_CTRL, word_t'(1 << CTRL_ARM), rdata);

		test_name = "led while armed";
		for (int i = 0; i < 4; i++) begin
			show_probe(miss_probe(bp));
			wb_xfer(1'b0, ADR_CTRL, '0, rdata);
			check_val("ctrl armed", word_t'(1 << CTRL_ST_ARMED), rdata);
		end

		hit        = rand_probe();
		hit.exe_pc = bp;
		test_name  = "led frozen";
		show_probe(hit);
		// Inputs keep moving, the snapshot must not
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			probe <= rand_probe();
			sw    <= {SEL_EXE_PC, 8'($random(seed))};
		end

		tries = 0;
		rdata = '0;
		while (!rdata[CTRL_ST_FROZEN]) begin
			if (tries == POLL_LIMIT) begin
				abort_on_timeout("the frozen state");
			end
			tries++;
			wb_xfer(1'b0, ADR_CTRL, '0, rdata);
		end
		check_val("ctrl frozen", word_t'(1 << CTRL_ST_FROZEN), rdata);
		wb_xfer(1'b0, SEL_ALU_RES, '0, rdata);
		check_val("frozen alu_res", ref_word(SEL_ALU_RES, hit, sw), rdata);
		wb_xfer(1'b0, SEL_REG_BASE + 8'd5, '0, rdata);
		check_val("frozen reg 5", ref_word(SEL_REG_BASE + 8'd5, hit, sw), rdata);

		check_en = 1'b0;
		wb_xfer(1'b1, ADR_CTRL, word_t'(1 << CTRL_RELEASE), rdata);
		test_name = "led after release";
		show_probe(rand_probe());
		show_probe(rand_probe());
		wb_xfer(1'b0, ADR_CTRL, '0, rdata);
		check_val("ctrl released", 16'h0000, rdata);

		check_en = 1'b0;
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/debug_monitor_top.sv
`default_nettype none

module debug_monitor_top
	import dbg_types_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  word_t      sw,
	input  cpu_probe_t probe,
	output word_t      led,

	// Wishbone slave
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  probe_sel_t wb_adr,
	input  word_t      wb_dat_w,
	output word_t      wb_dat_r,
	output logic       wb_ack
);

	probe_sel_t     sel_stable;
	logic           arm_req;
	logic           release_req;
	word_t          bp_pc;
	logic           snap_en;
	capture_state_t cap_state;
	cpu_probe_t     snap;
	word_t          wb_probe_word;

	sel_debounce sel_debounce_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.sel_raw    (sw[15:8]),
		.sel_stable (sel_stable)
	);

	capture_fsm capture_fsm_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.arm_req     (arm_req),
		.release_req (release_req),
		.exe_pc      (probe.exe_pc),
		.bp_pc       (bp_pc),
		.snap_en     (snap_en),
		.cap_state   (cap_state)
	);

	probe_snapshot probe_snapshot_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.snap_en (snap_en),
		.probe   (probe),
		.snap    (snap)
	);

	////////////////////
	// Word select for LEDs and bus

	led_probe_mux led_mux_i (
		.sel  (sel_stable),
		.snap (snap),
		.sw   (sw),
		.word (led)
	);

	led_probe_mux wb_mux_i (
		.sel  (wb_adr),
		.snap (snap),
		.sw   (sw),
		.word (wb_probe_word)
	);

	wb_probe_port wb_probe_port_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.probe_word  (wb_probe_word),
		.cap_state   (cap_state),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.arm_req     (arm_req),
		.release_req (release_req),
		.bp_pc       (bp_pc)
	);

endmodule

`default_nettype wire

// File: hw/wb_probe_port.sv
`default_nettype none

module wb_probe_port
	import dbg_types_pkg::*, dbg_map_pkg::*;
(
	input  logic           clk,
	input  logic           arst_n,
	input  logic           wb_cyc,
	input  logic           wb_stb,
	input  logic           wb_we,
	input  probe_sel_t     wb_adr,
	input  word_t          wb_dat_w,
	input  word_t          probe_word,
	input  capture_state_t cap_state,
	output word_t          wb_dat_r,
	output logic           wb_ack,
	output logic           arm_req,
	output logic           release_req,
	output word_t          bp_pc
);

	logic  req;
	logic  wr_ctrl;
	word_t ctrl_rd;
	word_t rd_word;

	// New cycle seen, ack follows on the next edge
	assign req     = wb_cyc && wb_stb && !wb_ack;
	assign wr_ctrl = req && wb_we && (wb_adr == ADR_CTRL);

	assign arm_req     = wr_ctrl && wb_dat_w[CTRL_ARM];
	assign release_req = wr_ctrl && wb_dat_w[CTRL_RELEASE];

	always_comb begin
		ctrl_rd                 = '0;
		ctrl_rd[CTRL_ST_ARMED]  = (cap_state == CAP_ARMED);
		ctrl_rd[CTRL_ST_FROZEN] = (cap_state == CAP_FROZEN);

		case (wb_adr)
			ADR_CTRL:  rd_word = ctrl_rd;
			ADR_BP_PC: rd_word = bp_pc;
			default:   rd_word = probe_word;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
			bp_pc  <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we && wb_adr == ADR_BP_PC) begin
				bp_pc <= wb_dat_w;
			end
		end
	end

	// Read data valid with ack
	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_word;
		end
	end

	////////////////////
	// Checks

	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_ack |-> (wb_cyc && wb_stb)
	);

endmodule

`default_nettype wire

// File: hw/led_probe_mux.sv
`default_nettype none

module led_probe_mux
	import dbg_types_pkg::*, dbg_map_pkg::*;
(
	input  probe_sel_t sel,
	input  cpu_probe_t snap,
	input  word_t      sw,
	output word_t      word
);

	word_t     flags_word;
	reg_addr_t reg_idx;

	// Each flag followed by a dark LED
	assign flags_word = {
		snap.flags.mem_read,      1'b0,
		snap.flags.mem_write,     1'b0,
		snap.flags.reg_write,     1'b0,
		snap.flags.alu_flag,      1'b0,
		snap.flags.hold,          1'b0,
		snap.flags.flush,         1'b0,
		snap.flags.decoder_error, 1'b0,
		snap.flags.data_ready,    1'b0
	};

	assign reg_idx = reg_addr_t'(sel - SEL_REG_BASE);

	always_comb begin
		case (sel) inside
			SEL_FLAGS: begin
				word = flags_word;
			end

			////////////////////
			// Fetch and decode
			SEL_IF_PC: begin
				word = snap.if_pc;
			end
			SEL_IF_INST: begin
				word = snap.if_inst;
			end
			SEL_ID_INST: begin
				word = snap.id_inst;
			end
			SEL_ID_PC: begin
				word = snap.id_pc;
			end

			////////////////////
			// Execute and memory
			SEL_EXE_PC: begin
				word = snap.exe_pc;
			end
			SEL_ALU_OP1: begin
				word = snap.alu_op1;
			end
			SEL_ALU_OP2: begin
				word = snap.alu_op2;
			end
			SEL_ALU_RES: begin
				word = snap.alu_res;
			end
			SEL_WB_RES: begin
				word = snap.wb_res;
			end
			SEL_MEM_DATA: begin
				word = snap.mem_data;
			end
			SEL_MEM_ADDR: begin
				word = snap.mem_addr;
			end

			// Register file, one code per register
			[SEL_REG_BASE:SEL_REG_LAST]: begin
				word = snap.regs[reg_idx];
			end

			default: begin
				word = sw;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/probe_snapshot.sv
`default_nettype none

module probe_snapshot
	import dbg_types_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       snap_en,
	input  cpu_probe_t probe,
	output cpu_probe_t snap
);

	cpu_probe_t snap_q;

	// One copy for both the LEDs and the bus
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			snap_q <= '0;
		end else if (snap_en) begin
			snap_q <= probe;
		end
	end

	assign snap = snap_q;

endmodule

`default_nettype wire

// File: hw/capture_fsm.sv
`default_nettype none

module capture_fsm
	import dbg_types_pkg::*;
(
	input  logic           clk,
	input  logic           arst_n,
	input  logic           arm_req,
	input  logic           release_req,
	input  word_t          exe_pc,
	input  word_t          bp_pc,
	output logic           snap_en,
	output capture_state_t cap_state
);

	capture_state_t state_q;
	capture_state_t state_d;
	logic           bp_hit;

	// Breakpoint compare on the live execute PC
	assign bp_hit = (exe_pc == bp_pc);

	always_comb begin
		state_d = state_q;

		case (state_q)
			CAP_LIVE: begin
				if (arm_req) begin
					state_d = CAP_ARMED;
				end
			end
			CAP_ARMED: begin
				if (bp_hit) begin
					state_d = CAP_FROZEN;
				end
			end
			CAP_FROZEN: begin
				state_d = CAP_FROZEN;
			end
			default: begin
				state_d = CAP_LIVE;
			end
		endcase

		// Release wins from any state
		if (release_req) begin
			state_d = CAP_LIVE;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= CAP_LIVE;
		end else begin
			state_q <= state_d;
		end
	end

	// Still enabled on the hit edge, so the matching probe is kept
	assign snap_en   = (state_q != CAP_FROZEN);
	assign cap_state = state_q;

	////////////////////
	// Checks

	a_frozen_no_load: assert property (
		@(posedge clk) disable iff (!arst_n)
		(cap_state == CAP_FROZEN) |-> !snap_en
	);

	a_frozen_from_armed: assert property (
		@(posedge clk) disable iff (!arst_n)
		(cap_state == CAP_FROZEN && $past(cap_state) != CAP_FROZEN)
			|-> ($past(cap_state) == CAP_ARMED)
	);

endmodule

`default_nettype wire

// File: hw/sel_debounce.sv
`default_nettype none

module sel_debounce
	import dbg_types_pkg::*, dbg_map_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  probe_sel_t sel_raw,
	output probe_sel_t sel_stable
);

	typedef logic [DEBOUNCE_CNT_W-1:0] cnt_t;

	probe_sel_t sel_last;
	cnt_t       stable_cnt;
	logic       sel_changed;

	assign sel_changed = (sel_raw != sel_last);

	// stable_cnt is the number of edges sel_last has been seen in a row
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_last   <= '0;
			stable_cnt <= '0;
			sel_stable <= '0;
		end else begin
			sel_last <= sel_raw;

			if (sel_changed) begin
				stable_cnt <= cnt_t'(1);
			end else if (stable_cnt != cnt_t'(DEBOUNCE_CYCLES)) begin
				stable_cnt <= stable_cnt + cnt_t'(1);
			end

			// Held long enough, pass it on
			if (stable_cnt == cnt_t'(DEBOUNCE_CYCLES)) begin
				sel_stable <= sel_last;
			end
		end
	end

	////////////////////
	// Checks

	a_cnt_bound: assert property (
		@(posedge clk) disable iff (!arst_n)
		stable_cnt <= cnt_t'(DEBOUNCE_CYCLES)
	);

endmodule

`default_nettype wire

// File: hw/dbg_map_pkg.sv
`default_nettype none

package dbg_map_pkg;

	import dbg_types_pkg::*;

	////////////////////
	// LED select codes

	localparam probe_sel_t SEL_FLAGS    = 8'h00;
	localparam probe_sel_t SEL_IF_PC    = 8'h0F;
	localparam probe_sel_t SEL_IF_INST  = 8'h10;
	localparam probe_sel_t SEL_ID_INST  = 8'h13;
	localparam probe_sel_t SEL_ID_PC    = 8'h14;
	localparam probe_sel_t SEL_EXE_PC   = 8'h16;
	localparam probe_sel_t SEL_ALU_OP1  = 8'h19;
	localparam probe_sel_t SEL_ALU_OP2  = 8'h1A;
	localparam probe_sel_t SEL_ALU_RES  = 8'h1B;
	localparam probe_sel_t SEL_WB_RES   = 8'h20;
	localparam probe_sel_t SEL_MEM_DATA = 8'h25;
	localparam probe_sel_t SEL_MEM_ADDR = 8'h26;

	// General registers occupy one code each, starting here
	localparam probe_sel_t SEL_REG_BASE = 8'h30;
	localparam probe_sel_t SEL_REG_LAST = SEL_REG_BASE + probe_sel_t'(REG_COUNT - 1);

	////////////////////
	// Bus registers

	localparam probe_sel_t ADR_CTRL  = 8'hF0;
	localparam probe_sel_t ADR_BP_PC = 8'hF1;

	// Write side of ADR_CTRL
	localparam int CTRL_ARM     = 0;
	localparam int CTRL_RELEASE = 1;

	// Read side of ADR_CTRL
	localparam int CTRL_ST_ARMED  = 0;
	localparam int CTRL_ST_FROZEN = 1;

	////////////////////
	// Switch debounce

	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

endpackage

`default_nettype wire

// File: hw/dbg_types_pkg.sv
`default_nettype none

package dbg_types_pkg;

	localparam int WORD_W     = 16;
	localparam int SEL_W      = 8;
	localparam int REG_COUNT  = 8;
	localparam int REG_ADDR_W = 3;

	////////////////////
	// Basic words

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Also used as the Wishbone word address
	typedef logic [SEL_W-1:0]      probe_sel_t;

	////////////////////
	// CPU probe

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic alu_flag;
		logic hold;
		logic flush;
		logic decoder_error;
		logic data_ready;
	} probe_flags_t;

	typedef struct packed {
		word_t                if_pc;
		word_t                if_inst;
		word_t                id_pc;
		word_t                id_inst;
		word_t                exe_pc;
		word_t                alu_op1;
		word_t                alu_op2;
		word_t                alu_res;
		word_t                wb_res;
		word_t                mem_addr;
		word_t                mem_data;
		probe_flags_t         flags;
		word_t [REG_COUNT-1:0] regs;
	} cpu_probe_t;

	typedef enum logic [1:0] {
		CAP_LIVE   = 2'd0,
		CAP_ARMED  = 2'd1,
		CAP_FROZEN = 2'd2
	} capture_state_t;

endpackage

`default_nettype wire
